/* Bender.yml */
package:
  name: fcore_subsystem

sources:
  - files:
      - hdl/fcore_pkg.sv
      - hdl/dp_ram.sv
      - hdl/register_file.sv
      - hdl/regfile_arbiter.sv
      - hdl/exec_unit.sv
      - hdl/dma_engine.sv
      - hdl/fcore_subsystem.sv
  - target: test
    files:
      - testbench/tb_fcore_subsystem.sv

# Simulation top: tb_fcore_subsystem
# Design top: fcore_subsystem

/* fcore_subsystem.f */
hdl/fcore_pkg.sv
hdl/dp_ram.sv
hdl/register_file.sv
hdl/regfile_arbiter.sv
hdl/exec_unit.sv
hdl/dma_engine.sv
hdl/fcore_subsystem.sv
testbench/tb_fcore_subsystem.sv

/* hdl/dma_engine.sv */
/*
 * DMA engine for host access to the register file.
 * Host requests are queued in a circular buffer and executed one per cycle
 * while the arbiter grants access. Reads answer one cycle after issue.
 */

`timescale 1ns/1ps

module dma_engine #(
    parameter int dma_fifo_depth = 4
) (
    input  logic                              clock,
    input  logic                              rst,
    input  logic                              req_valid,
    input  fcore_pkg::dma_req_t               req,
    input  logic                              dma_grant,
    output logic                              dma_pending,
    output logic                              rf_wr_valid,
    output fcore_pkg::rf_write_t              rf_wr,
    output logic [fcore_pkg::addr_bits_c-1:0] rf_rd_addr,
    input  logic [fcore_pkg::reg_width_c-1:0] rf_rd_data,
    output logic                              resp_valid,
    output fcore_pkg::dma_resp_t              resp,
    output logic                              overflow
);

    import fcore_pkg::*;

    localparam int ptr_w = bits_for(dma_fifo_depth);
    localparam int cnt_w = bits_for(dma_fifo_depth + 1);
    localparam logic [ptr_w-1:0] last_slot  = ptr_w'(dma_fifo_depth - 1);
    localparam logic [cnt_w-1:0] full_count = cnt_w'(dma_fifo_depth);

    dma_req_t               queue [dma_fifo_depth];
    dma_req_t               head;
    logic [ptr_w-1:0]       wr_ptr;
    logic [ptr_w-1:0]       rd_ptr;
    logic [cnt_w-1:0]       count;
    logic                   full;
    logic                   push;
    logic                   pop;
    logic                   rd_issued;
    logic [addr_bits_c-1:0] rd_addr_q;

    function automatic logic [ptr_w-1:0] next_ptr(logic [ptr_w-1:0] p);
        return (p == last_slot) ? '0 : p + 1'b1;
    endfunction

    assign full        = (count == full_count);
    assign dma_pending = (count != '0);
    assign push        = req_valid && !full;
    assign pop         = dma_grant && dma_pending;
    assign head        = queue[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            queue[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            overflow  <= 1'b0;
            rd_issued <= 1'b0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            if (req_valid && full) overflow <= 1'b1;
            rd_issued <= pop && !head.is_write;
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            rd_addr_q <= head.addr;
        end
    end

    assign rf_wr_valid = pop && head.is_write;
    assign rf_wr       = '{addr: head.addr, data: head.data};
    assign rf_rd_addr  = head.addr;

    // Read data arrives from the register file the cycle after issue
    assign resp_valid = rd_issued;
    assign resp       = '{addr: rd_addr_q, data: rf_rd_data};

    // Pointers and occupancy count are kept separately and must agree
    assert property (@(posedge clock) disable iff (rst) pop |-> (rd_ptr != wr_ptr) || full)
        else $error("DMA queue popped while empty");

endmodule

/* hdl/dp_ram.sv */
/*
 * Simple dual-port RAM, one write port and one read port.
 * Reads are registered with one cycle of latency and return the old
 * contents when the same word is written in the same cycle.
 */

`timescale 1ns/1ps

module dp_ram #(
    parameter int data_width = 32,
    parameter int addr_width = 5
) (
    input  logic                  clock,
    input  logic                  we,
    input  logic [addr_width-1:0] wr_addr,
    input  logic [data_width-1:0] wr_data,
    input  logic [addr_width-1:0] rd_addr,
    output logic [data_width-1:0] rd_data
);

    logic [data_width-1:0] mem [2**addr_width];

    // Nonblocking update keeps read-before-write ordering
    always_ff @(posedge clock) begin
        rd_data <= mem[rd_addr];
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

/* hdl/exec_unit.sv */
/*
 * Two stage execution pipeline.
 * Stage 1 decodes the incoming word and addresses the register file, stage 2
 * computes on the returned operands and writes the result back.
 */

`timescale 1ns/1ps

module exec_unit (
    input  logic                              clock,
    input  logic                              rst,
    input  logic                              instr_valid,
    input  fcore_pkg::instr_t                 instr,
    input  logic                              core_hold,
    output logic [fcore_pkg::addr_bits_c-1:0] rd_addr_a,
    output logic [fcore_pkg::addr_bits_c-1:0] rd_addr_b,
    input  logic [fcore_pkg::reg_width_c-1:0] rd_data_a,
    input  logic [fcore_pkg::reg_width_c-1:0] rd_data_b,
    output logic                              wr_valid,
    output fcore_pkg::rf_write_t              wr,
    output logic                              exec_busy,
    output logic                              instr_dropped
);

    import fcore_pkg::*;

    logic                   accept;
    logic                   s2_valid;
    opcode_e                s2_op;
    logic [addr_bits_c-1:0] s2_dest;
    logic [15:0]            s2_imm;
    logic [reg_width_c-1:0] alu_result;

    assign accept = instr_valid && !core_hold;

    // Source fields are presented straight from the bus so the RAM
    // captures them on the same edge as the strobe
    assign rd_addr_a = instr.reg_form.src_a;
    assign rd_addr_b = instr.reg_form.src_b;

    always_ff @(posedge clock) begin
        if (rst) begin
            s2_valid      <= 1'b0;
            instr_dropped <= 1'b0;
        end else begin
            s2_valid <= accept;
            if (instr_valid && core_hold) begin
                instr_dropped <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            s2_op   <= instr.reg_form.opcode;
            s2_dest <= instr.reg_form.dest;
            s2_imm  <= instr.imm_form.imm;
        end
    end

    always_comb begin
        case (s2_op)
            op_add:  alu_result = rd_data_a + rd_data_b;
            op_sub:  alu_result = rd_data_a - rd_data_b;
            // Only the low half of the product is kept
            op_mul:  alu_result = rd_data_a * rd_data_b;
            op_ldi:  alu_result = sign_extend(s2_imm);
            default: alu_result = '0;
        endcase
    end

    // Nops and undefined opcodes leave the register file alone
    assign wr_valid  = s2_valid && (s2_op inside {op_add, op_sub, op_mul, op_ldi});
    assign wr.addr   = s2_dest;
    assign wr.data   = alu_result;
    assign exec_busy = s2_valid;

endmodule

/* hdl/fcore_pkg.sv */
/*
 * Shared types and helpers for the arithmetic core.
 * Holds the instruction word formats, the register write port and the DMA
 * request and response records. Modules import it inside their bodies.
 */

package fcore_pkg;

    localparam int reg_width_c = 32;
    localparam int addr_bits_c = 5;

    typedef enum logic [3:0] {
        op_nop = 4'h0,
        op_add = 4'h1,
        op_sub = 4'h2,
        op_mul = 4'h3,
        op_ldi = 4'h4
    } opcode_e;

    // Three register operands
    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] dest;
        logic [4:0] src_a;
        logic [4:0] src_b;
        logic [12:0] unused;
    } reg_form_t;

    // Destination plus a signed 16 bit constant
    typedef struct packed {
        opcode_e            opcode;
        logic [4:0]         dest;
        logic [6:0]         unused;
        logic signed [15:0] imm;
    } imm_form_t;

    // Both formats share the opcode and destination positions
    typedef union packed {
        reg_form_t reg_form;
        imm_form_t imm_form;
    } instr_t;

    typedef struct packed {
        logic [addr_bits_c-1:0] addr;
        logic [reg_width_c-1:0] data;
    } rf_write_t;

    typedef struct packed {
        logic                   is_write;
        logic [addr_bits_c-1:0] addr;
        logic [reg_width_c-1:0] data;
    } dma_req_t;

    typedef struct packed {
        logic [addr_bits_c-1:0] addr;
        logic [reg_width_c-1:0] data;
    } dma_resp_t;

    // Bits needed to index n items, never less than one
    function automatic int bits_for(int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    function automatic logic [reg_width_c-1:0] sign_extend(logic [15:0] imm);
        return {{(reg_width_c-16){imm[15]}}, imm};
    endfunction

endpackage

/* hdl/fcore_subsystem.sv */
/*
 * Top level of the arithmetic core.
 * Connects the execution unit and the DMA engine to the shared register
 * file through the arbiter and sets the sizing parameters.
 */

`timescale 1ns/1ps

module fcore_subsystem #(
    parameter int file_depth      = 32,
    parameter int reg_per_channel = 16,
    parameter int dma_fifo_depth  = 4,
    parameter int dma_burst       = 4
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  fcore_pkg::instr_t     instr,
    input  logic                  dma_req_valid,
    input  fcore_pkg::dma_req_t   dma_req,
    output logic                  core_hold,
    output logic                  instr_dropped,
    output logic                  dma_resp_valid,
    output fcore_pkg::dma_resp_t  dma_resp,
    output logic                  dma_overflow
);

    import fcore_pkg::*;

    logic [addr_bits_c-1:0] core_rd_addr_a;
    logic [addr_bits_c-1:0] core_rd_addr_b;
    logic [reg_width_c-1:0] core_rd_data_a;
    logic [reg_width_c-1:0] core_rd_data_b;
    logic                   core_wr_valid;
    rf_write_t              core_wr;
    logic [addr_bits_c-1:0] dma_rd_addr;
    logic [reg_width_c-1:0] dma_rd_data;
    logic                   dma_wr_valid;
    rf_write_t              dma_wr;
    logic                   dma_pending;
    logic                   dma_grant;
    logic                   exec_busy;

    register_file #(
        .file_depth(file_depth),
        .reg_per_channel(reg_per_channel)
    ) u_register_file (
        .clock(clock),
        .dma_grant(dma_grant),
        .core_wr_valid(core_wr_valid),
        .core_wr(core_wr),
        .core_rd_addr_a(core_rd_addr_a),
        .core_rd_addr_b(core_rd_addr_b),
        .core_rd_data_a(core_rd_data_a),
        .core_rd_data_b(core_rd_data_b),
        .dma_wr_valid(dma_wr_valid),
        .dma_wr(dma_wr),
        .dma_rd_addr(dma_rd_addr),
        .dma_rd_data(dma_rd_data)
    );

    regfile_arbiter #(
        .dma_burst(dma_burst)
    ) u_arbiter (
        .clock(clock),
        .rst(rst),
        .dma_pending(dma_pending),
        .exec_busy(exec_busy),
        .dma_grant(dma_grant),
        .core_hold(core_hold)
    );

    exec_unit u_exec_unit (
        .clock(clock),
        .rst(rst),
        .instr_valid(instr_valid),
        .instr(instr),
        .core_hold(core_hold),
        .rd_addr_a(core_rd_addr_a),
        .rd_addr_b(core_rd_addr_b),
        .rd_data_a(core_rd_data_a),
        .rd_data_b(core_rd_data_b),
        .wr_valid(core_wr_valid),
        .wr(core_wr),
        .exec_busy(exec_busy),
        .instr_dropped(instr_dropped)
    );

    dma_engine #(
        .dma_fifo_depth(dma_fifo_depth)
    ) u_dma_engine (
        .clock(clock),
        .rst(rst),
        .req_valid(dma_req_valid),
        .req(dma_req),
        .dma_grant(dma_grant),
        .dma_pending(dma_pending),
        .rf_wr_valid(dma_wr_valid),
        .rf_wr(dma_wr),
        .rf_rd_addr(dma_rd_addr),
        .rf_rd_data(dma_rd_data),
        .resp_valid(dma_resp_valid),
        .resp(dma_resp),
        .overflow(dma_overflow)
    );

endmodule

/* hdl/regfile_arbiter.sv */
/*
 * Arbiter between the execution unit and the DMA engine.
 * Grants the register file to DMA once the pipeline is empty and limits
 * each grant to a burst, with a one cycle release for the core after it.
 */

`timescale 1ns/1ps

module regfile_arbiter #(
    parameter int dma_burst = 4
) (
    input  logic clock,
    input  logic rst,
    input  logic dma_pending,
    input  logic exec_busy,
    output logic dma_grant,
    output logic core_hold
);

    import fcore_pkg::*;

    localparam int burst_w = bits_for(dma_burst);
    localparam logic [burst_w-1:0] last_op = burst_w'(dma_burst - 1);

    logic [burst_w-1:0] op_count;
    logic               release_q;
    logic               burst_done;

    // An operation is performed on every granted cycle with a queued request
    assign burst_done = dma_grant && dma_pending && (op_count == last_op);

    always_ff @(posedge clock) begin
        if (rst) begin
            dma_grant <= 1'b0;
            release_q <= 1'b0;
            op_count  <= '0;
        end else begin
            release_q <= burst_done;
            if (dma_grant) begin
                if (burst_done || !dma_pending) begin
                    dma_grant <= 1'b0;
                    op_count  <= '0;
                end else begin
                    op_count <= op_count + 1'b1;
                end
            end else if (dma_pending && !exec_busy && !release_q) begin
                // Skipping the release cycle lets a core instruction issued there be seen
                dma_grant <= 1'b1;
            end
        end
    end

    assign core_hold = (dma_pending || dma_grant) && !release_q;

    assert property (@(posedge clock) disable iff (rst)
        dma_grant |-> !exec_busy)
        else $error("DMA grant held with an instruction in stage 2");

endmodule

/* hdl/register_file.sv */
/*
 * Register file built from two mirrored dual-port RAMs.
 * The core gets two read ports and one write port; under DMA grant the
 * DMA engine owns the write port and reads through the first RAM.
 */

`timescale 1ns/1ps

module register_file #(
    parameter int file_depth      = 32,
    parameter int reg_per_channel = 16
) (
    input  logic                                clock,
    input  logic                                dma_grant,
    input  logic                                core_wr_valid,
    input  fcore_pkg::rf_write_t                core_wr,
    input  logic [fcore_pkg::addr_bits_c-1:0]   core_rd_addr_a,
    input  logic [fcore_pkg::addr_bits_c-1:0]   core_rd_addr_b,
    output logic [fcore_pkg::reg_width_c-1:0]   core_rd_data_a,
    output logic [fcore_pkg::reg_width_c-1:0]   core_rd_data_b,
    input  logic                                dma_wr_valid,
    input  fcore_pkg::rf_write_t                dma_wr,
    input  logic [fcore_pkg::addr_bits_c-1:0]   dma_rd_addr,
    output logic [fcore_pkg::reg_width_c-1:0]   dma_rd_data
);

    import fcore_pkg::*;

    localparam int ram_addr_w = $clog2(file_depth);

    logic                   ram_we;
    logic [ram_addr_w-1:0]  ram_wr_addr;
    logic [reg_width_c-1:0] ram_wr_data;
    logic [ram_addr_w-1:0]  ram_a_rd_addr;
    logic [ram_addr_w-1:0]  ram_b_rd_addr;
    logic [reg_width_c-1:0] ram_a_rd_data;
    logic [reg_width_c-1:0] ram_b_rd_data;
    logic                   dma_rd_sel;

    if (ram_addr_w != addr_bits_c) begin : g_depth_check
        $error("file_depth does not match the register address width");
    end

    dp_ram #(
        .data_width(reg_width_c),
        .addr_width(ram_addr_w)
    ) mem_a (
        .clock(clock),
        .we(ram_we),
        .wr_addr(ram_wr_addr),
        .wr_data(ram_wr_data),
        .rd_addr(ram_a_rd_addr),
        .rd_data(ram_a_rd_data)
    );

    dp_ram #(
        .data_width(reg_width_c),
        .addr_width(ram_addr_w)
    ) mem_b (
        .clock(clock),
        .we(ram_we),
        .wr_addr(ram_wr_addr),
        .wr_data(ram_wr_data),
        .rd_addr(ram_b_rd_addr),
        .rd_data(ram_b_rd_data)
    );

    // Write and read address muxing follows the current mode
    always_comb begin
        if (dma_grant) begin
            ram_we        = dma_wr_valid;
            ram_wr_addr   = dma_wr.addr;
            ram_wr_data   = dma_wr.data;
            ram_a_rd_addr = dma_rd_addr;
            ram_b_rd_addr = dma_rd_addr;
        end else begin
            ram_we        = core_wr_valid;
            ram_wr_addr   = core_wr.addr;
            // First register of each channel always holds zero in core mode
            ram_wr_data   = (core_wr.addr % reg_per_channel != 0) ? core_wr.data : '0;
            ram_a_rd_addr = core_rd_addr_a;
            ram_b_rd_addr = core_rd_addr_b;
        end
    end

    // Read data returns a cycle late, so steer it with the mode of the read
    always_ff @(posedge clock) begin
        dma_rd_sel <= dma_grant;
    end

    assign dma_rd_data    = dma_rd_sel ? ram_a_rd_data : '0;
    assign core_rd_data_a = dma_rd_sel ? '0 : ram_a_rd_data;
    assign core_rd_data_b = dma_rd_sel ? '0 : ram_b_rd_data;

    // The arbiter must keep the execution unit drained before granting DMA
    assert property (@(posedge clock) core_wr_valid |-> !dma_grant)
        else $error("core write during DMA grant");

endmodule

/* testbench/tb_fcore_subsystem.sv */
/*
 * Directed testbench for the arithmetic core.
 * Drives instructions and DMA requests, keeps a reference copy of the
 * register file and checks every DMA read-back against that copy.
 */

`timescale 1ns/1ps

module tb_fcore_subsystem;

    import fcore_pkg::*;

    localparam int num_regs    = 32;
    localparam int channel_len = 16;
    localparam int fifo_depth  = 4;
    localparam int burst_reqs  = 6;
    localparam int wait_limit  = 200;

    logic      clock;
    logic      rst;
    logic      instr_valid;
    instr_t    instr;
    logic      dma_req_valid;
    dma_req_t  dma_req;
    logic      core_hold;
    logic      instr_dropped;
    logic      dma_resp_valid;
    dma_resp_t dma_resp;
    logic      dma_overflow;

    logic [31:0] model [num_regs];
    logic [31:0] rng_state;
    dma_resp_t   resp_q [$];
    logic        watch_release;
    logic        hold_fell;

    fcore_subsystem uut (
        .clock(clock),
        .rst(rst),
        .instr_valid(instr_valid),
        .instr(instr),
        .dma_req_valid(dma_req_valid),
        .dma_req(dma_req),
        .core_hold(core_hold),
        .instr_dropped(instr_dropped),
        .dma_resp_valid(dma_resp_valid),
        .dma_resp(dma_resp),
        .dma_overflow(dma_overflow)
    );

    always #10 clock = ~clock;

    // Outputs settle after the rising edge, so responses are collected on the falling edge
    always @(negedge clock) begin
        if (watch_release && !core_hold && resp_q.size() < burst_reqs) begin
            hold_fell = 1'b1;
        end
        if (dma_resp_valid) begin
            resp_q.push_back(dma_resp);
        end
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] expected);
        $display("[FAIL] %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, expected);
        abort_run();
    endtask

    task automatic stop_with_error(string why);
        $display("Error at %0t ns: %s", $time, why);
        abort_run();
    endtask

    task automatic expect_bit(string name, logic got, logic expected);
        assert (got === expected) else report_mismatch(name, got, expected);
    endtask

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] expected_result(opcode_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_mul:  return a * b;
            default: return 32'h0;
        endcase
    endfunction

    // Core writes to the first register of a channel always land as zero
    function automatic void model_core_write(logic [4:0] dest, logic [31:0] value);
        model[dest] = (dest % channel_len == 0) ? 32'h0 : value;
    endfunction

    function automatic instr_t reg_instr(opcode_e op, logic [4:0] dest, logic [4:0] a,
                                         logic [4:0] b);
        instr_t w;
        w = '0;
        w.reg_form.opcode = op;
        w.reg_form.dest   = dest;
        w.reg_form.src_a  = a;
        w.reg_form.src_b  = b;
        return w;
    endfunction

    function automatic instr_t imm_instr(logic [4:0] dest, logic [15:0] imm);
        instr_t w;
        w = '0;
        w.imm_form.opcode = op_ldi;
        w.imm_form.dest   = dest;
        w.imm_form.imm    = imm;
        return w;
    endfunction

    task automatic drive_instr(instr_t w);
        @(posedge clock);
        instr_valid   <= 1'b1;
        instr         <= w;
        dma_req_valid <= 1'b0;
    endtask

    task automatic drive_dma(logic wr, logic [4:0] a, logic [31:0] d);
        @(posedge clock);
        dma_req_valid <= 1'b1;
        dma_req       <= '{is_write: wr, addr: a, data: d};
        instr_valid   <= 1'b0;
    endtask

    task automatic drive_idle();
        @(posedge clock);
        instr_valid   <= 1'b0;
        dma_req_valid <= 1'b0;
    endtask

    // Two low samples in a row rule out the single release cycle between bursts
    task automatic wait_idle();
        int low_run;
        int i;
        low_run = 0;
        for (i = 0; i < wait_limit && low_run < 2; i++) begin
            @(negedge clock);
            low_run = core_hold ? 0 : low_run + 1;
        end
        if (low_run < 2) begin
            stop_with_error("core_hold did not fall after the DMA requests");
        end else begin
            @(posedge clock);
        end
    endtask

    task automatic wait_responses(int n);
        int i;
        for (i = 0; i < wait_limit && resp_q.size() < n; i++) begin
            @(posedge clock);
        end
        if (resp_q.size() < n) begin
            stop_with_error($sformatf("only %0d of %0d DMA responses arrived", resp_q.size(), n));
        end
    endtask

    task automatic check_resp(logic [4:0] addr);
        dma_resp_t r;
        r = resp_q.pop_front();
        assert (r.addr == addr) else report_mismatch("dma_resp.addr", r.addr, addr);
        assert (r.data == model[addr]) else report_mismatch("dma_resp.data", r.data, model[addr]);
    endtask

    task automatic dma_write(logic [4:0] addr, logic [31:0] data);
        drive_dma(1'b1, addr, data);
        drive_idle();
        model[addr] = data;
        wait_idle();
    endtask

    task automatic dma_read_check(logic [4:0] addr);
        drive_dma(1'b0, addr, '0);
        drive_idle();
        wait_responses(1);
        check_resp(addr);
        wait_idle();
    endtask

    task automatic queue_reg_op(opcode_e op, logic [4:0] dest, logic [4:0] a, logic [4:0] b);
        model_core_write(dest, expected_result(op, model[a], model[b]));
        drive_instr(reg_instr(op, dest, a, b));
    endtask

    task automatic queue_ldi(logic [4:0] dest, logic [15:0] imm);
        model_core_write(dest, {{16{imm[15]}}, imm});
        drive_instr(imm_instr(dest, imm));
    endtask

    // DMA writes bypass the channel zero rule, so registers 0 and 16 keep their data
    task automatic test_dma_all();
        for (int r = 0; r < num_regs; r++) begin
            dma_write(5'(r), xorshift32());
        end
        for (int r = 0; r < num_regs; r++) begin
            dma_read_check(5'(r));
        end
    endtask

    task automatic test_ldi();
        logic [31:0] rnd;
        rnd = xorshift32();
        queue_ldi(5'd7, 16'h8001);
        queue_ldi(5'd8, 16'h1234);
        queue_ldi(5'd9, rnd[15:0]);
        queue_ldi(5'd0, 16'h4321);
        queue_ldi(5'd16, 16'hf00d);
        drive_idle();
        wait_idle();
        dma_read_check(5'd7);
        dma_read_check(5'd8);
        dma_read_check(5'd9);
        dma_read_check(5'd0);
        dma_read_check(5'd16);
    endtask

    // Each dependent instruction is followed by an idle cycle
    task automatic test_arith();
        dma_write(5'd3, xorshift32());
        dma_write(5'd4, xorshift32());
        queue_reg_op(op_add, 5'd20, 5'd3, 5'd4);
        drive_idle();
        queue_reg_op(op_sub, 5'd21, 5'd20, 5'd5);
        drive_idle();
        queue_reg_op(op_mul, 5'd22, 5'd21, 5'd6);
        drive_idle();
        queue_reg_op(op_mul, 5'd23, 5'd22, 5'd22);
        drive_idle();
        queue_reg_op(op_add, 5'd16, 5'd1, 5'd2);
        drive_idle();
        wait_idle();
        for (int r = 20; r <= 23; r++) begin
            dma_read_check(5'(r));
        end
        dma_read_check(5'd16);
    endtask

    task automatic test_pipeline();
        queue_reg_op(op_add, 5'd24, 5'd1, 5'd2);
        queue_reg_op(op_sub, 5'd25, 5'd3, 5'd4);
        queue_reg_op(op_mul, 5'd26, 5'd5, 5'd6);
        queue_ldi(5'd27, 16'hfffe);
        queue_reg_op(op_add, 5'd28, 5'd7, 5'd8);
        drive_idle();
        wait_idle();
        for (int r = 24; r <= 28; r++) begin
            dma_read_check(5'(r));
        end
        @(negedge clock);
        expect_bit("instr_dropped", instr_dropped, 1'b0);
    endtask

    task automatic test_hold_drop();
        // The load lands while the read is queued, so it must be ignored
        drive_dma(1'b0, 5'd9, '0);
        drive_instr(imm_instr(5'd9, ~model[9][15:0]));
        drive_idle();
        wait_responses(1);
        check_resp(5'd9);
        wait_idle();
        dma_read_check(5'd9);
        @(negedge clock);
        expect_bit("instr_dropped", instr_dropped, 1'b1);
        expect_bit("dma_overflow", dma_overflow, 1'b0);
    endtask

    task automatic test_overflow();
        dma_resp_t r;
        int n;
        int last;
        for (int i = 0; i < 3 * fifo_depth; i++) begin
            drive_dma(1'b0, 5'(i + 1), '0);
        end
        drive_idle();
        wait_idle();
        n = resp_q.size();
        assert (n >= fifo_depth && n < 3 * fifo_depth)
            else stop_with_error($sformatf("%0d DMA responses after a queue overflow", n));
        last = 0;
        while (resp_q.size() > 0) begin
            r = resp_q[0];
            assert (r.addr > last) else stop_with_error("DMA responses arrived out of order");
            last = r.addr;
            check_resp(r.addr);
        end
        @(negedge clock);
        expect_bit("dma_overflow", dma_overflow, 1'b1);
    endtask

    task automatic test_burst_release();
        hold_fell = 1'b0;
        for (int i = 0; i < burst_reqs; i++) begin
            drive_dma(1'b0, 5'(20 + i), '0);
        end
        watch_release = 1'b1;
        drive_idle();
        wait_responses(burst_reqs);
        watch_release = 1'b0;
        assert (hold_fell) else stop_with_error("core_hold never fell during the DMA burst");
        for (int i = 0; i < burst_reqs; i++) begin
            check_resp(5'(20 + i));
        end
        wait_idle();
    endtask

    initial begin
        clock         = 1'b0;
        rst           = 1'b1;
        instr_valid   = 1'b0;
        instr         = '0;
        dma_req_valid = 1'b0;
        dma_req       = '0;
        rng_state     = 32'd55686;
        watch_release = 1'b0;
        hold_fell     = 1'b0;
        repeat (4) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        expect_bit("core_hold", core_hold, 1'b0);
        expect_bit("dma_resp_valid", dma_resp_valid, 1'b0);
        expect_bit("instr_dropped", instr_dropped, 1'b0);
        expect_bit("dma_overflow", dma_overflow, 1'b0);
        test_dma_all();
        test_ldi();
        test_arith();
        test_pipeline();
        test_hold_drop();
        test_overflow();
        test_burst_release();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
